// File: mem_pkg.sv
package mem_pkg;

    // Widths of the SRAM side
    localparam int sram_addr_w = 18;
    localparam int sram_data_w = 16;

    // Processor side
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // SRAM side
    typedef logic [sram_addr_w-1:0] sram_addr_t;
    typedef logic [sram_data_w-1:0] sram_data_t;

    // One word spans an even and an odd location
    typedef logic [sram_addr_w-2:0] word_index_t;

    typedef enum logic [1:0] {
        sram_idle,
        sram_read,
        sram_write
    } sram_state_t;

    // Data memory starts here in the processor byte space
    localparam addr_t default_mem_base = 32'd1024;

    // Index of the last cycle of one SRAM access, at least 5
    localparam int default_sram_wait_cycles = 6;

endpackage

// File: mem_access_unit.sv
`timescale 1ns/100ps

module mem_access_unit #(
    parameter mem_pkg::addr_t mem_base = mem_pkg::default_mem_base
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  mem_pkg::addr_t       address,
    input  mem_pkg::word_t       write_data,
    input  logic                 ctrl_busy,
    input  logic                 op_done,
    input  mem_pkg::word_t       rdata,
    output mem_pkg::word_t       read_data,
    output logic                 freeze,
    output logic                 done,
    output logic                 start,
    output logic                 start_write,
    output mem_pkg::word_index_t word_index,
    output mem_pkg::word_t       wdata
);
    import mem_pkg::*;

    localparam int index_lsb = 2;  // Byte offset within a word
    localparam int index_msb = index_lsb + $bits(word_index_t) - 1;

    addr_t offset;
    logic  request;
    logic  in_range;
    logic  issued;

    assign request = mem_read | mem_write;

    // Offset into data memory
    assign offset = address - mem_base;

    // Below the base, or past the last SRAM word
    assign in_range = (address >= mem_base) &&
                      (offset[$bits(addr_t)-1:index_msb+1] == '0);

    assign word_index = offset[index_msb:index_lsb];
    assign wdata      = write_data;
    assign start_write = mem_write & ~mem_read;  // Read wins if both are set

    // One strobe per request
    assign start = request & in_range & ~issued & ~ctrl_busy;

    // Out-of-range requests complete at once
    assign done = request & (~in_range | (issued & op_done));

    // Stall the pipeline until the completion cycle
    assign freeze = request & ~done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issued <= 1'b0;
        end else if (done) begin
            issued <= 1'b0;
        end else if (start) begin
            issued <= 1'b1;
        end
    end

    // Word for write-back, held until the next read completes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_data <= '0;
        end else if (done && mem_read) begin
            if (in_range) begin
                read_data <= rdata;
            end else begin
                read_data <= '0;  // Outside the window
            end
        end
    end

endmodule

// File: sram_controller.sv
`timescale 1ns/100ps

module sram_controller #(
    parameter int sram_wait_cycles = mem_pkg::default_sram_wait_cycles
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 start_write,
    input  mem_pkg::word_index_t word_index,
    input  mem_pkg::word_t       wdata,
    output logic                 ctrl_busy,
    output logic                 op_done,
    output mem_pkg::word_t       rdata,
    inout  wire mem_pkg::sram_data_t sram_dq,
    output mem_pkg::sram_addr_t  sram_addr,
    output logic                 sram_ub_n,
    output logic                 sram_lb_n,
    output logic                 sram_we_n,
    output logic                 sram_ce_n,
    output logic                 sram_oe_n
);
    import mem_pkg::*;

    localparam int cnt_w = $clog2(sram_wait_cycles + 1);

    localparam logic [cnt_w-1:0] last_count = cnt_w'(sram_wait_cycles);

    // Read schedule
    localparam logic [cnt_w-1:0] rd_hi_capture = cnt_w'(1);
    localparam logic [cnt_w-1:0] rd_odd_start  = cnt_w'(2);
    localparam logic [cnt_w-1:0] rd_lo_capture = cnt_w'(3);

    // Write schedule
    localparam logic [cnt_w-1:0] wr_hi_pulse   = cnt_w'(1);
    localparam logic [cnt_w-1:0] wr_odd_start  = cnt_w'(3);
    localparam logic [cnt_w-1:0] wr_lo_pulse   = cnt_w'(4);

    sram_state_t      state;
    logic [cnt_w-1:0] count;
    word_index_t      index_q;
    word_t            wdata_q;
    sram_data_t       rdata_hi;
    sram_data_t       rdata_lo;
    logic             odd_half;
    logic             drive_dq;

    // State and the access counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sram_idle;
            count <= '0;
        end else begin
            case (state)
                sram_idle: begin
                    count <= '0;
                    if (start) begin
                        state <= start_write ? sram_write : sram_read;
                    end
                end
                default: begin
                    if (count == last_count) begin
                        state <= sram_idle;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
            endcase
        end
    end

    // Request held for the whole access
    always_ff @(posedge clk) begin
        if (state == sram_idle && start) begin
            index_q <= word_index;
            wdata_q <= wdata;
        end
    end

    // Halves sampled at the end of their second cycle
    always_ff @(posedge clk) begin
        if (state == sram_read) begin
            if (count == rd_hi_capture) begin
                rdata_hi <= sram_dq;
            end
            if (count == rd_lo_capture) begin
                rdata_lo <= sram_dq;
            end
        end
    end

    assign rdata = {rdata_hi, rdata_lo};

    assign ctrl_busy = (state != sram_idle);
    assign op_done   = (state != sram_idle) && (count == last_count);

    // Even location first, it holds the high half
    always_comb begin
        case (state)
            sram_read:  odd_half = (count >= rd_odd_start);
            sram_write: odd_half = (count >= wr_odd_start);
            default:    odd_half = 1'b0;
        endcase
    end

    assign sram_addr = {index_q, odd_half};

    assign sram_ce_n = (state == sram_idle);
    assign sram_ub_n = (state == sram_idle);  // Full 16-bit transfers
    assign sram_lb_n = (state == sram_idle);
    assign sram_oe_n = (state != sram_read);

    // One short strobe per half, address and data settle around it
    assign sram_we_n = !((state == sram_write) &&
                         (count == wr_hi_pulse || count == wr_lo_pulse));

    assign drive_dq = (state == sram_write);
    assign sram_dq  = drive_dq ? (odd_half ? wdata_q[15:0] : wdata_q[31:16]) : 'z;

endmodule

// File: mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem #(
    parameter mem_pkg::addr_t mem_base         = mem_pkg::default_mem_base,
    parameter int             sram_wait_cycles = mem_pkg::default_sram_wait_cycles
) (
    input  logic                clk,
    input  logic                rst,
    // Memory stage
    input  logic                mem_read,
    input  logic                mem_write,
    input  mem_pkg::addr_t      address,
    input  mem_pkg::word_t      write_data,
    output mem_pkg::word_t      read_data,
    output logic                freeze,
    output logic                done,
    // SRAM pins, controls active low
    inout  wire mem_pkg::sram_data_t sram_dq,
    output mem_pkg::sram_addr_t sram_addr,
    output logic                sram_ub_n,
    output logic                sram_lb_n,
    output logic                sram_we_n,
    output logic                sram_ce_n,
    output logic                sram_oe_n
);
    import mem_pkg::*;

    logic        start;
    logic        start_write;
    logic        ctrl_busy;
    logic        op_done;
    word_index_t word_index;
    word_t       wdata;
    word_t       rdata;

    mem_access_unit #(
        .mem_base(mem_base)
    ) mem_access_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .address    (address),
        .write_data (write_data),
        .ctrl_busy  (ctrl_busy),
        .op_done    (op_done),
        .rdata      (rdata),
        .read_data  (read_data),
        .freeze     (freeze),
        .done       (done),
        .start      (start),
        .start_write(start_write),
        .word_index (word_index),
        .wdata      (wdata)
    );

    sram_controller #(
        .sram_wait_cycles(sram_wait_cycles)
    ) sram_controller_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .start_write(start_write),
        .word_index (word_index),
        .wdata      (wdata),
        .ctrl_busy  (ctrl_busy),
        .op_done    (op_done),
        .rdata      (rdata),
        .sram_dq    (sram_dq),
        .sram_addr  (sram_addr),
        .sram_ub_n  (sram_ub_n),
        .sram_lb_n  (sram_lb_n),
        .sram_we_n  (sram_we_n),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n)
    );

endmodule

// File: sram_model.sv
`timescale 1ns/100ps

module sram_model (
    inout  wire mem_pkg::sram_data_t dq,
    input  mem_pkg::sram_addr_t      addr,
    input  logic                     ub_n,
    input  logic                     lb_n,
    input  logic                     we_n,
    input  logic                     ce_n,
    input  logic                     oe_n
);
    import mem_pkg::*;

    localparam int depth = 2 ** sram_addr_w;

    sram_data_t mem [depth];
    logic       read_en;

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // Output drivers on only while OE is low and no write strobe
    assign read_en = !ce_n && !oe_n && we_n && !ub_n && !lb_n;
    assign dq      = read_en ? mem[addr] : 'z;

    // Data latched at the trailing edge of the write strobe
    always @(posedge we_n) begin
        if (ce_n == 1'b0) begin
            if (!ub_n) begin
                mem[addr][15:8] <= dq[15:8];
            end
            if (!lb_n) begin
                mem[addr][7:0] <= dq[7:0];
            end
        end
    end

endmodule

// File: mem_checker.sv
`timescale 1ns/100ps

module mem_checker #(
    parameter mem_pkg::addr_t mem_base         = mem_pkg::default_mem_base,
    parameter int             sram_wait_cycles = mem_pkg::default_sram_wait_cycles
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_read,
    input  logic           mem_write,
    input  mem_pkg::addr_t address,
    input  mem_pkg::word_t exp_data,
    input  mem_pkg::word_t read_data,
    input  logic           freeze,
    input  logic           done,
    input  logic           sram_ub_n,
    input  logic           sram_lb_n,
    input  logic           sram_we_n,
    input  logic           sram_ce_n,
    input  logic           sram_oe_n,
    output int             error_count
);
    import mem_pkg::*;

    localparam addr_t window_bytes = addr_t'(2) << sram_addr_w;  // Two bytes per location

    int    errors = 0;
    int    wait_count;
    word_t held;
    logic  seen_request;

    assign error_count = errors;

    function automatic logic in_window(input addr_t a);
        return (a >= mem_base) && ((a - mem_base) < window_bytes);
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    always @(posedge clk or posedge rst) begin
        int expected_wait;
        if (rst) begin
            wait_count   <= 0;
            held         <= '0;
            seen_request <= 1'b0;
        end else begin
            check_word("read_data", held, read_data);  // Zero until the first read completes
            if (mem_read || mem_write) begin
                seen_request <= 1'b1;
                if (done) begin
                    expected_wait = in_window(address) ? sram_wait_cycles + 1 : 0;
                    if (wait_count != expected_wait) begin
                        $display("Done for address %h came after %0d stalled cycles, not %0d",
                                 address, wait_count, expected_wait);
                        errors++;
                    end
                    check_bit("freeze", 1'b0, freeze);
                    wait_count <= 0;
                    if (mem_read) begin
                        held <= exp_data;
                    end
                end else begin
                    check_bit("freeze", 1'b1, freeze);
                    wait_count <= wait_count + 1;
                end
            end else begin
                check_bit("done", 1'b0, done);
                check_bit("freeze", 1'b0, freeze);
                if (!seen_request) begin
                    // Chip idle until the first request
                    check_bit("sram_ub_n", 1'b1, sram_ub_n);
                    check_bit("sram_lb_n", 1'b1, sram_lb_n);
                    check_bit("sram_we_n", 1'b1, sram_we_n);
                    check_bit("sram_ce_n", 1'b1, sram_ce_n);
                    check_bit("sram_oe_n", 1'b1, sram_oe_n);
                end
            end
        end
    end

endmodule

// File: tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam addr_t base_addr   = default_mem_base;
    localparam int    wait_cycles = default_sram_wait_cycles;
    localparam int    max_lines   = 64;

    logic            clk = 1'b0;
    logic            rst;
    logic            mem_read;
    logic            mem_write;
    addr_t           address;
    word_t           write_data;
    word_t           exp_data;
    word_t           read_data;
    logic            freeze;
    logic            done;
    wire sram_data_t sram_dq;
    sram_addr_t      sram_addr;
    logic            sram_ub_n;
    logic            sram_lb_n;
    logic            sram_we_n;
    logic            sram_ce_n;
    logic            sram_oe_n;
    int              check_errors;
    int              other_errors = 0;
    int              line_count = 0;
    int              cycle_count = 0;
    int              cycle_limit = 0;
    byte             trace_op    [max_lines];
    addr_t           trace_addr  [max_lines];
    word_t           trace_wdata [max_lines];
    word_t           trace_exp   [max_lines];

    always #2 clk = ~clk;  // 4 ns period

    mem_subsystem #(
        .mem_base        (base_addr),
        .sram_wait_cycles(wait_cycles)
    ) mem_subsystem_inst (
        .clk(clk), .rst(rst),
        .mem_read(mem_read), .mem_write(mem_write),
        .address(address), .write_data(write_data),
        .read_data(read_data), .freeze(freeze), .done(done),
        .sram_dq(sram_dq), .sram_addr(sram_addr),
        .sram_ub_n(sram_ub_n), .sram_lb_n(sram_lb_n), .sram_we_n(sram_we_n),
        .sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n)
    );

    sram_model sram_model_inst (
        .dq(sram_dq), .addr(sram_addr), .ub_n(sram_ub_n), .lb_n(sram_lb_n),
        .we_n(sram_we_n), .ce_n(sram_ce_n), .oe_n(sram_oe_n)
    );

    mem_checker #(
        .mem_base        (base_addr),
        .sram_wait_cycles(wait_cycles)
    ) mem_checker_inst (
        .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
        .address(address), .exp_data(exp_data), .read_data(read_data),
        .freeze(freeze), .done(done), .sram_ub_n(sram_ub_n), .sram_lb_n(sram_lb_n),
        .sram_we_n(sram_we_n), .sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n),
        .error_count(check_errors)
    );

    task automatic load_trace();
        int    fd;
        int    fields;
        string line;
        byte   op;
        addr_t a;
        word_t wd;
        word_t ex;
        fd = $fopen("mem_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file mem_trace.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd) && line_count < max_lines) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
            fields = $sscanf(line, "%c %h %h %h", op, a, wd, ex);
            if (fields != 4 || (op != "R" && op != "W")) begin
                $display("Trace line not understood: %s", line);
                other_errors++;
                continue;
            end
            trace_op[line_count]    = op;
            trace_addr[line_count]  = a;
            trace_wdata[line_count] = wd;
            trace_exp[line_count]   = ex;
            line_count++;
        end
        $fclose(fd);
        if (line_count == 0) begin
            $display("The trace file holds no operations");
            other_errors++;
        end
    endtask

    task automatic apply_request(input int i);
        mem_read   <= (trace_op[i] == "R");
        mem_write  <= (trace_op[i] == "W");
        address    <= trace_addr[i];
        write_data <= trace_wdata[i];
        exp_data   <= trace_exp[i];
    endtask

    // Done sampled mid-cycle once it has settled
    task automatic wait_for_done();
        do begin
            @(negedge clk);
        end while (!done);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles with the trace unfinished",
                     cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        address    = '0;
        write_data = '0;
        exp_data   = '0;
        load_trace();
        cycle_limit = line_count * (mem_subsystem_inst.sram_wait_cycles + 3) + 50;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);  // Quiet cycles after reset
        for (int i = 0; i < line_count; i++) begin
            apply_request(i);
            wait_for_done();
            @(posedge clk);
        end
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);  // Checker done with the last edge
        $display("Summary: %0d check errors, %0d other errors", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: mem_trace.txt
# op address write_data expected_read, all hex
# op is R for a word read, W for a word write
W 00000400 12345678 00000000
W 00000404 9abcdef0 00000000
R 00000400 00000000 12345678
R 00000404 00000000 9abcdef0
R 00000408 00000000 00000000
W 00000408 ffff0000 00000000
W 0000040c 0000ffff 00000000
R 0000040c 00000000 0000ffff
R 00000408 00000000 ffff0000
W 000803fc 13579bdf 00000000
W 000003fc deadbeef 00000000
W 00080400 cafef00d 00000000
R 000803fc 00000000 13579bdf
R 000003fc 00000000 00000000
R 00080400 00000000 00000000
R 00000400 00000000 12345678
W 00000400 a5a55a5a 00000000
R 00000404 00000000 9abcdef0
R 00000400 00000000 a5a55a5a

// File: flist.f
mem_pkg.sv
mem_access_unit.sv
sram_controller.sv
mem_subsystem.sv
sram_model.sv
mem_checker.sv
tb_mem_subsystem.sv

// File: Makefile
TOP := tb_mem_subsystem

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep '^NO ERRORS$$' > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean
